// File: Bender.yml
package:
  name: decode_execute

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/id_ex_if.sv
      - verilog/instr_decoder.sv
      - verilog/reg_file.sv
      - verilog/id_ex_reg.sv
      - verilog/exec_stage.sv
      - verilog/decode_execute_top.sv
  - target: test
    files:
      - testbench/decode_execute_chk.sv
      - testbench/decode_execute_tb.sv

// File: decode_execute_top.f
verilog/rv_pkg.sv
verilog/id_ex_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/id_ex_reg.sv
verilog/exec_stage.sv
verilog/decode_execute_top.sv
testbench/decode_execute_chk.sv
testbench/decode_execute_tb.sv

// File: testbench/decode_execute_chk.sv
`timescale 1ns/1ps

module decode_execute_chk (
    input  logic                         clk,
    input  logic                         clear,
    input  logic                         instr_valid,
    input  logic                         instr_ready,
    input  logic [rv_pkg::data_size-1:0] instr,
    input  rv_pkg::pc_t                  instr_pc,
    input  logic                         wb_en,
    input  logic [4:0]                   wb_rd,
    input  logic [rv_pkg::data_size-1:0] wb_data,
    input  logic                         out_ready,
    input  logic                         ex_valid,
    input  logic [rv_pkg::data_size-1:0] ex_result,
    input  logic [rv_pkg::data_size-1:0] ex_store_data,
    input  logic [4:0]                   ex_rd,
    input  logic                         ex_reg_write,
    input  logic                         ex_mem_read,
    input  logic                         ex_mem_write,
    input  logic [2:0]                   ex_funct3,
    input  logic                         ex_branch_taken,
    input  rv_pkg::pc_t                  ex_branch_target
);

    logic [rv_pkg::data_size-1:0] shadow [0:31];
    logic [rv_pkg::data_size-1:0] exp_res;
    logic [rv_pkg::data_size-1:0] exp_store;
    logic [rv_pkg::data_size-1:0] exp_tgt;
    logic [3:0]                   exp_flags;        // reg_write, mem_read, mem_write, taken
    logic [7:0]                   exp_fields;       // rd and funct3
    logic                         exp_has_res;
    logic                         exp_has_tgt;
    logic [3:0]                   flags;
    int                           acc_count = 0;
    int                           take_count = 0;
    int                           fail_count = 0;

    assign flags = {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch_taken};

    // Value read on this edge, a write landing on the same edge included
    function automatic logic [31:0] src_value(input logic [4:0] r);
        if (r == 5'd0)
            return '0;
        if (wb_en && (wb_rd == r))
            return wb_data;
        return shadow[r];
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5: begin
                if (alt)
                    return $signed(x) >>> y[4:0];
                return x >> y[4:0];
            end
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Shadow register file and expected results of the accepted instruction
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk or posedge clear) begin : capture
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pcx;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        if (clear) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
            exp_flags   <= '0;
            exp_fields  <= '0;
            exp_has_res <= 1'b0;
            exp_has_tgt <= 1'b0;
            acc_count   <= 0;
            take_count  <= 0;
        end else begin
            if (ex_valid && out_ready)
                take_count <= take_count + 1;
            if (wb_en && (wb_rd != 5'd0))
                shadow[wb_rd] <= wb_data;
            if (instr_valid && instr_ready) begin
                a     = src_value(instr[19:15]);
                b     = src_value(instr[24:20]);
                f3    = instr[14:12];
                pcx   = 32'(instr_pc);
                imm_i = {{20{instr[31]}}, instr[31:20]};
                imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                acc_count   <= acc_count + 1;
                exp_fields  <= {instr[11:7], f3};
                exp_store   <= b;
                exp_has_res <= 1'b1;
                exp_has_tgt <= 1'b0;
                case (instr[6:0])
                    rv_pkg::op_reg: begin
                        exp_flags <= 4'b1000;
                        exp_res   <= alu_ref(f3, instr[30], a, b);
                    end
                    rv_pkg::op_imm: begin
                        exp_flags <= 4'b1000;
                        exp_res   <= alu_ref(f3, (f3 == 3'd5) && instr[30], a, imm_i);
                    end
                    rv_pkg::op_lui: begin
                        exp_flags <= 4'b1000;
                        exp_res   <= {instr[31:12], 12'b0};
                    end
                    rv_pkg::op_auipc: begin
                        exp_flags <= 4'b1000;
                        exp_res   <= pcx + {instr[31:12], 12'b0};
                    end
                    rv_pkg::op_jal: begin
                        exp_flags   <= 4'b1001;
                        exp_res     <= pcx + 32'd4;
                        exp_has_tgt <= 1'b1;
                        exp_tgt     <= pcx + imm_j;
                    end
                    rv_pkg::op_jalr: begin
                        exp_flags   <= 4'b1001;
                        exp_res     <= pcx + 32'd4;
                        exp_has_tgt <= 1'b1;
                        exp_tgt     <= (a + imm_i) & ~32'd1;
                    end
                    rv_pkg::op_branch: begin
                        exp_flags   <= {3'b000, branch_ref(f3, a, b)};
                        exp_has_res <= 1'b0;
                        exp_has_tgt <= 1'b1;
                        exp_tgt     <= pcx + {{20{instr[31]}}, instr[7], instr[30:25],
                                              instr[11:8], 1'b0};
                    end
                    rv_pkg::op_load: begin
                        exp_flags <= 4'b1100;
                        exp_res   <= a + imm_i;             // Load address
                    end
                    rv_pkg::op_store: begin
                        exp_flags <= 4'b0010;
                        exp_res   <= a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    end
                    default: begin
                        exp_flags   <= 4'b0000;
                        exp_has_res <= 1'b0;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////////////////
    a_flags: assert property (@(posedge clk) disable iff (clear)
        flags == (ex_valid ? exp_flags : 4'b0000))
        else begin
            fail_count++;
            $error("[ERROR] %0t control flags expected %b actual %b", $time,
                   $sampled(ex_valid) ? $sampled(exp_flags) : 4'b0000, $sampled(flags));
        end

    a_fields: assert property (@(posedge clk) disable iff (clear)
        ex_valid |-> {ex_rd, ex_funct3} == exp_fields)
        else begin
            fail_count++;
            $error("[ERROR] %0t {ex_rd,ex_funct3} expected %h actual %h", $time,
                   $sampled(exp_fields), $sampled({ex_rd, ex_funct3}));
        end

    a_result: assert property (@(posedge clk) disable iff (clear)
        ex_valid && exp_has_res |-> ex_result == exp_res)
        else begin
            fail_count++;
            $error("[ERROR] %0t ex_result expected %h actual %h", $time,
                   $sampled(exp_res), $sampled(ex_result));
        end

    a_target: assert property (@(posedge clk) disable iff (clear)
        ex_valid && exp_has_tgt |-> ex_branch_target == rv_pkg::pc_t'(exp_tgt))
        else begin
            fail_count++;
            $error("[ERROR] %0t ex_branch_target expected %h actual %h", $time,
                   rv_pkg::pc_t'($sampled(exp_tgt)), $sampled(ex_branch_target));
        end

    a_store: assert property (@(posedge clk) disable iff (clear)
        ex_valid && ex_mem_write |-> ex_store_data == exp_store)
        else begin
            fail_count++;
            $error("[ERROR] %0t ex_store_data expected %h actual %h", $time,
                   $sampled(exp_store), $sampled(ex_store_data));
        end

    a_ready: assert property (@(posedge clk) disable iff (clear)
        instr_ready == (!ex_valid || out_ready))
        else begin
            fail_count++;
            $error("[ERROR] %0t instr_ready expected %b actual %b", $time,
                   !$sampled(ex_valid) || $sampled(out_ready), $sampled(instr_ready));
        end

    a_stall: assert property (@(posedge clk) disable iff (clear)
        ex_valid && !out_ready |=> ex_valid && $stable(ex_result) && $stable(ex_store_data)
            && $stable(ex_branch_target) && $stable(flags) && $stable({ex_rd, ex_funct3}))
        else begin
            fail_count++;
            $error("[ERROR] %0t execute outputs changed while the stage was stalled", $time);
        end

    a_count: assert property (@(posedge clk) disable iff (clear)
        take_count <= acc_count && acc_count <= take_count + 1)
        else begin
            fail_count++;
            $error("[ERROR] %0t an instruction was lost or delivered twice", $time);
        end

endmodule

bind decode_execute_top decode_execute_chk chk (.*);

// File: testbench/decode_execute_tb.sv
`timescale 1ns/1ps

module decode_execute_tb;

    localparam int period = 40;

    logic                         clk;
    logic                         clear;
    logic                         instr_valid;
    logic                         instr_ready;
    logic [rv_pkg::data_size-1:0] instr;
    rv_pkg::pc_t                  instr_pc;
    logic                         wb_en;
    logic [4:0]                   wb_rd;
    logic [rv_pkg::data_size-1:0] wb_data;
    logic                         out_ready;
    logic                         ex_valid;
    logic [rv_pkg::data_size-1:0] ex_result;
    logic [rv_pkg::data_size-1:0] ex_store_data;
    logic [4:0]                   ex_rd;
    logic                         ex_reg_write;
    logic                         ex_mem_read;
    logic                         ex_mem_write;
    logic [2:0]                   ex_funct3;
    logic                         ex_branch_taken;
    rv_pkg::pc_t                  ex_branch_target;

    int          seed = 92;
    int          end_errors = 0;
    int          prog_len = 0;
    logic [31:0] program_q [$];

    decode_execute_top UUT (.*);

    // Picks x0 or one of the preloaded registers x1 to x8
    function automatic logic [4:0] rand_reg();
        return 5'($unsigned($random(seed)) % 9);
    endfunction

    task automatic build_program();
        logic [11:0] imm;
        logic [12:0] off;
        logic [4:0]  r;
        for (int f = 0; f < 8; f++) begin
            imm = 12'($random(seed));
            if (f == 1 || f == 5)
                imm[11:5] = 7'h00;                      // Shift immediates
            program_q.push_back({7'h00, rand_reg(), rand_reg(), 3'(f), rand_reg(),
                                 rv_pkg::op_reg});
            program_q.push_back({imm, rand_reg(), 3'(f), rand_reg(), rv_pkg::op_imm});
            if (f != 2 && f != 3) begin
                r   = rand_reg();
                off = 13'($random(seed));
                program_q.push_back({off[12], off[10:5], r, r, 3'(f), off[4:1], off[11],
                                     rv_pkg::op_branch});
                program_q.push_back({off[12], off[10:5], rand_reg(), r, 3'(f), off[4:1],
                                     off[11], rv_pkg::op_branch});
            end
        end
        program_q.push_back({7'h20, rand_reg(), rand_reg(), 3'b000, rand_reg(), rv_pkg::op_reg});
        program_q.push_back({7'h20, rand_reg(), rand_reg(), 3'b101, rand_reg(), rv_pkg::op_reg});
        program_q.push_back({7'h20, 5'($random(seed)), rand_reg(), 3'b101, rand_reg(),
                             rv_pkg::op_imm});
        program_q.push_back({20'($random(seed)), rand_reg(), rv_pkg::op_lui});
        program_q.push_back({20'($random(seed)), rand_reg(), rv_pkg::op_auipc});
        program_q.push_back({20'($random(seed)), rand_reg(), rv_pkg::op_jal});
        program_q.push_back({12'($random(seed)), rand_reg(), 3'b000, rand_reg(), rv_pkg::op_jalr});
        program_q.push_back({12'($random(seed)), rand_reg(), 3'b010, rand_reg(), rv_pkg::op_load});
        program_q.push_back({7'($random(seed)), rand_reg(), rand_reg(), 3'b010,
                             5'($random(seed)), rv_pkg::op_store});
    endtask

    // Holds one instruction until accepted, with random stalls and write-backs
    task automatic send(input logic [31:0] word);
        logic accepted;
        instr_valid = 1'b1;
        instr       = word;
        accepted    = 1'b0;
        while (!accepted) begin
            out_ready = (($random(seed) & 3) != 0);
            wb_en     = 1'($random(seed));
            wb_rd     = rand_reg();
            wb_data   = $random(seed);
            @(negedge clk);
            accepted = instr_ready;
            @(posedge clk);
            #2;
        end
        instr_valid = 1'b0;
        instr_pc    = instr_pc + 12'd4;
    endtask

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #1;
        repeat ((prog_len + 8) * 200 + 100) @(posedge clk);
        $display("Watchdog expired at %0t before the instruction stream finished", $time);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clear       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = 12'h100;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        out_ready   = 1'b1;
        build_program();
        prog_len = program_q.size();
        repeat (10) @(posedge clk);
        #2 clear = 1'b0;

        ////////////////////////////////////////////////////////////////////
        // Preload x1 to x8 through the write-back port
        ////////////////////////////////////////////////////////////////////
        for (int r = 1; r <= 8; r++) begin
            @(posedge clk);
            #2;
            wb_en   = 1'b1;
            wb_rd   = 5'(r);
            wb_data = $random(seed);
        end
        @(posedge clk);
        #2 wb_en = 1'b0;

        foreach (program_q[i]) begin
            send(program_q[i]);
        end
        out_ready = 1'b1;
        wb_en     = 1'b0;
        while (ex_valid) begin
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);

        if (UUT.chk.acc_count != prog_len) begin
            $display("[ERROR] %0t acc_count expected %0d actual %0d", $time,
                     prog_len, UUT.chk.acc_count);
            end_errors++;
        end
        if (UUT.chk.take_count != UUT.chk.acc_count) begin
            $display("[ERROR] %0t take_count expected %0d actual %0d", $time,
                     UUT.chk.acc_count, UUT.chk.take_count);
            end_errors++;
        end
        $display("Errors: %0d assertion failures, %0d end of run count errors",
                 UUT.chk.fail_count, end_errors);
        if (UUT.chk.fail_count == 0 && end_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog/decode_execute_top.sv
`timescale 1ns/1ps

module decode_execute_top (
    input  logic                         clk,
    input  logic                         clear,

    input  logic                         instr_valid,
    output logic                         instr_ready,
    input  logic [rv_pkg::data_size-1:0] instr,
    input  rv_pkg::pc_t                  instr_pc,

    input  logic                         wb_en,
    input  logic [4:0]                   wb_rd,
    input  logic [rv_pkg::data_size-1:0] wb_data,

    input  logic                         out_ready,
    output logic                         ex_valid,
    output logic [rv_pkg::data_size-1:0] ex_result,
    output logic [rv_pkg::data_size-1:0] ex_store_data,
    output logic [4:0]                   ex_rd,
    output logic                         ex_reg_write,
    output logic                         ex_mem_read,
    output logic                         ex_mem_write,
    output logic [2:0]                   ex_funct3,
    output logic                         ex_branch_taken,
    output rv_pkg::pc_t                  ex_branch_target
);

    id_ex_if id_ex ();

    logic advance;
    logic taken_raw;

    // Stage moves when empty or when its result leaves this cycle
    assign advance     = !id_ex.ex_valid || out_ready;
    assign instr_ready = advance;

    instr_decoder u_decoder (
        .instr (instr),
        .pc    (instr_pc),
        .valid (instr_valid),
        .id    (id_ex.decoder)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .clear   (clear),
        .rd_en   (advance),
        .rs1     (id_ex.id_dec.rs1),
        .rs2     (id_ex.id_dec.rs2),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rf      (id_ex.regs)
    );

    id_ex_reg u_id_ex_reg (
        .clk   (clk),
        .clear (clear),
        .load  (advance),
        .id    (id_ex.stage_in),
        .ex    (id_ex.stage_out)
    );

    exec_stage u_exec (
        .ex            (id_ex.execute),
        .result        (ex_result),
        .store_data    (ex_store_data),
        .branch_target (ex_branch_target),
        .branch_taken  (taken_raw)
    );

    //////////////////////////////////////////////////////////////////////
    // Outputs, side effects only while the stage holds an instruction
    //////////////////////////////////////////////////////////////////////
    assign ex_valid        = id_ex.ex_valid;
    assign ex_rd           = id_ex.ex_dec.rd;
    assign ex_funct3       = id_ex.ex_dec.funct3;
    assign ex_reg_write    = id_ex.ex_valid && id_ex.ex_dec.reg_write;
    assign ex_mem_read     = id_ex.ex_valid && id_ex.ex_dec.mem_read;
    assign ex_mem_write    = id_ex.ex_valid && id_ex.ex_dec.mem_write;
    assign ex_branch_taken = id_ex.ex_valid && taken_raw;

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    id_ex_if.execute                      ex,
    output logic [rv_pkg::data_size-1:0]  result,
    output logic [rv_pkg::data_size-1:0]  store_data,
    output rv_pkg::pc_t                   branch_target,
    output logic                          branch_taken
);

    logic [rv_pkg::data_size-1:0] pc_ext;
    logic [rv_pkg::data_size-1:0] op_a;
    logic [rv_pkg::data_size-1:0] op_b;
    logic [rv_pkg::data_size-1:0] alu_out;
    logic [rv_pkg::data_size-1:0] link;
    logic [rv_pkg::data_size-1:0] jalr_sum;
    logic [rv_pkg::data_size-1:0] target_sum;
    logic [4:0]                   shamt;
    logic                         eq;
    logic                         lt_s;
    logic                         lt_u;
    logic                         cond;

    assign pc_ext = {{(rv_pkg::data_size - rv_pkg::addr_size - 2){1'b0}}, ex.ex_dec.pc};

    //////////////////////////////////////////////////////////////////////
    // Operand selection and ALU
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ex.ex_dec.upper_sel)
            rv_pkg::upper_auipc: op_a = pc_ext;
            rv_pkg::upper_lui:   op_a = '0;
            default:             op_a = ex.rdata1;
        endcase
    end

    assign op_b  = ex.ex_dec.alu_src ? ex.ex_dec.imm : ex.rdata2;
    assign shamt = op_b[4:0];

    // Branches use register operands, so the comparator is shared with SLT
    assign eq   = (op_a == op_b);
    assign lt_s = ($signed(op_a) < $signed(op_b));
    assign lt_u = (op_a < op_b);

    always_comb begin
        case (ex.ex_dec.alu_op)
            rv_pkg::alu_add:    alu_out = op_a + op_b;
            rv_pkg::alu_sub:    alu_out = op_a - op_b;
            rv_pkg::alu_sll:    alu_out = op_a << shamt;
            rv_pkg::alu_slt:    alu_out = {{(rv_pkg::data_size-1){1'b0}}, lt_s};
            rv_pkg::alu_sltu:   alu_out = {{(rv_pkg::data_size-1){1'b0}}, lt_u};
            rv_pkg::alu_xor:    alu_out = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_out = op_a >> shamt;
            rv_pkg::alu_sra:    alu_out = $signed(op_a) >>> shamt;
            rv_pkg::alu_or:     alu_out = op_a | op_b;
            rv_pkg::alu_and:    alu_out = op_a & op_b;
            rv_pkg::alu_pass_b: alu_out = op_b;
            default:            alu_out = '0;
        endcase
    end

    assign link       = pc_ext + 32'd4;
    assign result     = (ex.ex_dec.wb_sel == rv_pkg::wb_pc_plus_4) ? link : alu_out;
    assign store_data = ex.rdata2;

    //////////////////////////////////////////////////////////////////////
    // Branch decision and target
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ex.ex_dec.funct3)
            3'b000:  cond = eq;                     // BEQ
            3'b001:  cond = !eq;                    // BNE
            3'b100:  cond = lt_s;
            3'b101:  cond = !lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = ex.ex_dec.jump || (ex.ex_dec.branch && cond);

    assign jalr_sum   = ex.rdata1 + ex.ex_dec.imm;
    assign target_sum = ex.ex_dec.jump_reg ? {jalr_sum[rv_pkg::data_size-1:1], 1'b0}
                                           : pc_ext + ex.ex_dec.imm;

    assign branch_target = rv_pkg::pc_t'(target_sum);  // Upper bits fall outside the PC range

endmodule

// File: verilog/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;

    // Decode side, combinational from the instruction word
    rv_pkg::decoded_t              id_dec;
    logic                          id_valid;

    // Register file read data, registered on the same edge as the stage
    logic [rv_pkg::data_size-1:0]  rdata1;
    logic [rv_pkg::data_size-1:0]  rdata2;

    // Execute side, the ID/EX register contents
    rv_pkg::decoded_t              ex_dec;
    logic                          ex_valid;

    modport decoder (
        output id_dec,
        output id_valid
    );

    modport regs (
        output rdata1,
        output rdata2
    );

    modport stage_in (
        input  id_dec,
        input  id_valid
    );

    modport stage_out (
        output ex_dec,
        output ex_valid
    );

    modport execute (
        input  ex_dec,
        input  rdata1,
        input  rdata2
    );

endinterface

// File: verilog/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic        clk,
    input  logic        clear,
    input  logic        load,
    id_ex_if.stage_in   id,
    id_ex_if.stage_out  ex
);

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            ex.ex_dec   <= '0;                      // No write or store can leak out of reset
            ex.ex_valid <= 1'b0;
        end else if (load) begin
            ex.ex_dec   <= id.id_dec;
            ex.ex_valid <= id.id_valid;
        end
    end

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [rv_pkg::data_size-1:0] instr,
    input  rv_pkg::pc_t                  pc,
    input  logic                         valid,
    id_ex_if.decoder                     id
);

    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic                         bit30;
    logic [rv_pkg::data_size-1:0] imm_i;
    logic [rv_pkg::data_size-1:0] imm_s;
    logic [rv_pkg::data_size-1:0] imm_b;
    logic [rv_pkg::data_size-1:0] imm_u;
    logic [rv_pkg::data_size-1:0] imm_j;
    rv_pkg::decoded_t             dec;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    //////////////////////////////////////////////////////////////////////
    // Immediate formats, all sign extended from bit 31
    //////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Maps funct3 to an ALU operation; alt selects SUB or SRA
    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        dec        = '0;                            // Unknown opcodes write nothing
        dec.funct3 = funct3;
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.pc     = pc;
        case (opcode)
            rv_pkg::op_reg: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = arith_op(funct3, bit30);
            end
            rv_pkg::op_imm: begin
                dec.reg_write = 1'b1;
                dec.alu_src   = 1'b1;
                dec.imm       = imm_i;
                dec.alu_op    = arith_op(funct3, (funct3 == 3'b101) && bit30);
            end
            rv_pkg::op_lui: begin
                dec.reg_write = 1'b1;
                dec.alu_src   = 1'b1;
                dec.upper_sel = rv_pkg::upper_lui;
                dec.alu_op    = rv_pkg::alu_pass_b;
                dec.imm       = imm_u;
            end
            rv_pkg::op_auipc: begin
                dec.reg_write = 1'b1;
                dec.alu_src   = 1'b1;
                dec.upper_sel = rv_pkg::upper_auipc;
                dec.imm       = imm_u;
            end
            rv_pkg::op_load: begin
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
                dec.alu_src   = 1'b1;
                dec.wb_sel    = rv_pkg::wb_memory;
                dec.imm       = imm_i;
            end
            rv_pkg::op_store: begin
                dec.mem_write = 1'b1;
                dec.alu_src   = 1'b1;
                dec.imm       = imm_s;
            end
            rv_pkg::op_branch: begin
                dec.branch = 1'b1;                  // Compares rs1 with rs2 in the ALU path
                dec.imm    = imm_b;
            end
            rv_pkg::op_jal: begin
                dec.jump      = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_sel    = rv_pkg::wb_pc_plus_4;
                dec.imm       = imm_j;
            end
            rv_pkg::op_jalr: begin
                dec.jump      = 1'b1;
                dec.jump_reg  = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_src   = 1'b1;
                dec.wb_sel    = rv_pkg::wb_pc_plus_4;
                dec.imm       = imm_i;
            end
            default: ;
        endcase
    end

    assign id.id_dec   = dec;
    assign id.id_valid = valid;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                         clk,
    input  logic                         clear,
    input  logic                         rd_en,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  logic                         wb_en,
    input  logic [4:0]                   wb_rd,
    input  logic [rv_pkg::data_size-1:0] wb_data,
    id_ex_if.regs                        rf
);

    logic [rv_pkg::data_size-1:0] regs [1:31];     // x0 has no storage
    logic                         wr_act;

    assign wr_act = wb_en && (wb_rd != 5'd0);

    // Read value seen on this edge, including a write landing on the same edge
    function automatic logic [rv_pkg::data_size-1:0] read_port(input logic [4:0] sel);
        if (sel == 5'd0) begin
            return '0;
        end
        if (wr_act && (wb_rd == sel)) begin
            return wb_data;
        end
        return regs[sel];
    endfunction

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_act) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            rf.rdata1 <= '0;
            rf.rdata2 <= '0;
        end else if (rd_en) begin              // Holds under back-pressure
            rf.rdata1 <= read_port(rs1);
            rf.rdata2 <= read_port(rs2);
        end
    end

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

    localparam int data_size = 32;
    localparam int addr_size = 10;                  // Instruction address in words

    typedef logic [addr_size+1:0] pc_t;             // Byte address of one word

    //////////////////////////////////////////////////////////////////////
    // RV32I major opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_memory,
        wb_pc_plus_4
    } wb_sel_e;

    typedef enum logic [1:0] {
        upper_none,
        upper_auipc,
        upper_lui
    } upper_sel_e;

    typedef struct packed {
        logic                 branch;
        logic                 jump;
        logic                 jump_reg;         // JALR takes its target from rs1
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 alu_src;          // Operand B is the immediate
        wb_sel_e              wb_sel;
        upper_sel_e           upper_sel;
        alu_op_e              alu_op;
        logic [2:0]           funct3;
        logic [4:0]           rd;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [data_size-1:0] imm;
        pc_t                  pc;
    } decoded_t;

endpackage
